//--- files.f
vector_pkg.sv
vaddsub_if.sv
vaddsub.sv
vaddsub_unit.sv
vector_fpu_top.sv
tb_clk_gen.sv
tb_vector_fpu.sv

//--- run.sh
#!/bin/sh
# Build and run the vector FPU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f files.f \
  --top-module tb_vector_fpu \
  -Mdir obj_dir \
  -o sim_vector_fpu

./obj_dir/sim_vector_fpu > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"

//--- tb_vector_fpu.sv
`timescale 1ns/1ps

module tb_vector_fpu import vector_pkg::*; ();

  localparam int LANES = 4;
  localparam int VW    = LANES * 16;

  // Cycle budget per test, plus slack
  localparam int CYCLE_LIMIT = 6 + 8 + 6 + 4 + 26 + 9 + 13 + 40;

  // Operand pairs with exactly known sum and difference
  localparam logic [15:0] TAB_A [8] = '{16'h3C00, 16'h4000, 16'h3C00, 16'hC200,
                                        16'h0001, 16'h0200, 16'h4000, 16'hBC00};
  localparam logic [15:0] TAB_B [8] = '{16'h3800, 16'h3800, 16'h3C00, 16'h3C00,
                                        16'h0002, 16'h0200, 16'h3C00, 16'hBC00};
  localparam logic [15:0] TAB_SUM [8] = '{16'h3E00, 16'h4100, 16'h4000, 16'hC000,
                                          16'h0003, 16'h0400, 16'h4200, 16'hC000};
  localparam logic [15:0] TAB_DIFF [8] = '{16'h3800, 16'h3E00, 16'h0000, 16'hC400,
                                           16'h8001, 16'h0000, 16'h3C00, 16'h0000};

  logic             CLK;
  logic             nRST;
  logic             in_valid;
  vop_t             op;
  logic [LANES-1:0] mask;
  logic [VW-1:0]    va;
  logic [VW-1:0]    vb;
  logic [VW-1:0]    vd_old;
  logic             out_valid;
  logic [VW-1:0]    vd;
  logic [LANES-1:0] lane_ovf;
  logic             ovf_clr;
  logic             ovf_sticky;

  int               cycles = 0;
  int               checks = 0;
  int               errors = 0;
  logic [31:0]      lfsr   = 32'd74120;

  // Expected results, oldest first
  int               exp_due_q [$];
  logic [VW-1:0]    exp_vd_q  [$];
  logic [LANES-1:0] exp_ovf_q [$];

  tb_clk_gen u_clk_gen (
    .CLK  (CLK),
    .nRST (nRST)
  );

  vector_fpu_top #(
    .LANES (LANES)
  ) u_dut (
    .CLK        (CLK),
    .nRST       (nRST),
    .in_valid   (in_valid),
    .op         (op),
    .mask       (mask),
    .va         (va),
    .vb         (vb),
    .vd_old     (vd_old),
    .out_valid  (out_valid),
    .vd         (vd),
    .lane_ovf   (lane_ovf),
    .ovf_clr    (ovf_clr),
    .ovf_sticky (ovf_sticky)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[14:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  task automatic check_fp16(input string name, input fp16_t expv, input fp16_t act);
    checks++;
    if (act !== expv) begin
      errors++;
      $display("FAILED t=%0t %s expected %h got %h", $time, name, expv, act);
    end
  endtask

  task automatic check_bits(input string name, input logic [LANES-1:0] expv,
                            input logic [LANES-1:0] act);
    checks++;
    if (act !== expv) begin
      errors++;
      $display("FAILED t=%0t %s expected %b got %b", $time, name, expv, act);
    end
  endtask

  task automatic check_bit(input string name, input logic expv, input logic act);
    checks++;
    if (act !== expv) begin
      errors++;
      $display("FAILED t=%0t %s expected %b got %b", $time, name, expv, act);
    end
  endtask

  task automatic score_result();
    logic [VW-1:0] ev;
    ev = exp_vd_q.pop_front();
    void'(exp_due_q.pop_front());
    if (!out_valid) begin
      errors++;
      $display("Error at t=%0t: no out_valid in the cycle a result was due", $time);
      void'(exp_ovf_q.pop_front());
    end else begin
      for (int i = 0; i < LANES; i++) begin
        check_fp16($sformatf("vd[%0d]", i), ev[16*i +: 16], vd[16*i +: 16]);
      end
      check_bits("lane_ovf", exp_ovf_q.pop_front(), lane_ovf);
    end
  endtask

  // Cycle count, timeout and result checking 2 ns after each edge
  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
      $display("Result: FAILED");
      $finish;
    end else begin
      #2;
      if (exp_due_q.size() != 0 && exp_due_q[0] == cycles) begin
        score_result();
      end else if (nRST) begin
        check_bit("out_valid", 1'b0, out_valid);
      end
    end
  end

  task automatic issue_op(input vop_t o, input logic [LANES-1:0] m,
                          input logic [VW-1:0] a, input logic [VW-1:0] b,
                          input logic [VW-1:0] old, input logic [VW-1:0] ev,
                          input logic [LANES-1:0] eo);
    @(posedge CLK);
    #1;
    in_valid = 1'b1;
    op       = o;
    mask     = m;
    va       = a;
    vb       = b;
    vd_old   = old;
    exp_due_q.push_back(cycles + 2);  // Sampled next edge, out one edge later
    exp_vd_q.push_back(ev);
    exp_ovf_q.push_back(eo);
  endtask

  task automatic issue_table_op(input vop_t o, input logic [LANES-1:0] m,
                                input logic [3*LANES-1:0] idx, input logic [VW-1:0] old);
    logic [VW-1:0] a;
    logic [VW-1:0] b;
    logic [VW-1:0] ev;
    logic [2:0]    k;
    for (int i = 0; i < LANES; i++) begin
      k = idx[3*i +: 3];
      a[16*i +: 16] = TAB_A[k];
      b[16*i +: 16] = TAB_B[k];
      if (!m[i]) ev[16*i +: 16] = old[16*i +: 16];
      else ev[16*i +: 16] = (o == VOP_SUB) ? TAB_DIFF[k] : TAB_SUM[k];
    end
    issue_op(o, m, a, b, old, ev, '0);
  endtask

  task automatic issue_random_op();
    vop_t                o;
    logic [LANES-1:0]    m;
    logic [3*LANES-1:0]  idx;
    logic [VW-1:0]       old;
    o = vop_t'(rand_bits(1));
    m = LANES'(rand_bits(LANES));
    for (int i = 0; i < LANES; i++) begin
      idx[3*i +: 3]  = 3'(rand_bits(3));
      old[16*i +: 16] = rand_bits(16);
    end
    issue_table_op(o, m, idx, old);
  endtask

  task automatic drain();
    @(posedge CLK);
    #1;
    in_valid = 1'b0;
    while (exp_due_q.size() != 0) @(posedge CLK);
  endtask

  task automatic expect_sticky(input logic expv);
    @(posedge CLK);
    #2;
    check_bit("ovf_sticky", expv, ovf_sticky);
  endtask

  task automatic clear_sticky();
    @(posedge CLK);
    #1 ovf_clr = 1'b1;
    @(posedge CLK);
    #1 ovf_clr = 1'b0;
    #1 check_bit("ovf_sticky", 1'b0, ovf_sticky);
  endtask

  task automatic arith_exact();
    issue_table_op(VOP_ADD, 4'hF, {3'd5, 3'd4, 3'd3, 3'd0}, '0);
    issue_table_op(VOP_SUB, 4'hF, {3'd6, 3'd0, 3'd2, 3'd1}, '0);
    issue_table_op(VOP_ADD, 4'hF, {3'd2, 3'd1, 3'd7, 3'd6}, '0);
    issue_table_op(VOP_SUB, 4'hF, {3'd7, 3'd5, 3'd4, 3'd3}, '0);
    drain();
  endtask

  // NaN in, inf - inf, inf with finite, -inf + -inf
  task automatic special_values();
    issue_op(VOP_ADD, 4'hF, {16'hFC00, 16'h7C00, 16'h3C00, 16'h7C01},
             {16'hFC00, 16'hFC00, 16'hFE00, 16'h3C00}, '0,
             {16'hFC00, 16'h7E00, 16'h7E00, 16'h7E00}, '0);
    issue_op(VOP_SUB, 4'hF, {16'h3C00, 16'h4000, 16'h7C00, 16'h7C00},
             {16'h7D00, 16'h7C00, 16'h3C00, 16'h7C00}, '0,
             {16'h7E00, 16'hFC00, 16'h7C00, 16'h7E00}, '0);
    issue_op(VOP_ADD, 4'hF, {16'h7E00, 16'h7C00, 16'h3C00, 16'hFC00},
             {16'h3C00, 16'hBC00, 16'h7C00, 16'h4000}, '0,
             {16'h7E00, 16'h7C00, 16'h7C00, 16'hFC00}, '0);
    drain();
  endtask

  task automatic round_ties_even();
    // 2048+1, 2048+3, 1+2^-11, 1+3*2^-11
    issue_op(VOP_ADD, 4'hF, {16'h3C00, 16'h3C00, 16'h6800, 16'h6800},
             {16'h1600, 16'h1000, 16'h4200, 16'h3C00}, '0,
             {16'h3C02, 16'h3C00, 16'h6802, 16'h6800}, '0);
    drain();
  endtask

  task automatic overflow_status();
    issue_op(VOP_ADD, 4'hF, {16'h3C00, 16'h4000, 16'h3C00, 16'h7BFF},
             {16'h3C00, 16'h3C00, 16'h3800, 16'h7BFF}, '0,
             {16'h4000, 16'h4200, 16'h3E00, 16'h7C00}, 4'b0001);
    drain();
    expect_sticky(1'b1);
    issue_table_op(VOP_SUB, 4'hF, {3'd0, 3'd1, 3'd2, 3'd3}, '0);
    drain();
    expect_sticky(1'b1);  // Holds until cleared
    clear_sticky();
    // Lane 0 masked off, old value must come back
    issue_op(VOP_ADD, 4'b1110, {16'h3C00, 16'h4000, 16'h3C00, 16'h7BFF},
             {16'h3C00, 16'h3C00, 16'h3800, 16'h7BFF}, {48'h0, 16'h1234},
             {16'h4000, 16'h4200, 16'h3E00, 16'h1234}, 4'b0000);
    drain();
    expect_sticky(1'b0);
  endtask

  task automatic mask_merge();
    repeat (6) issue_random_op();
    drain();
  endtask

  task automatic back_to_back();
    repeat (10) issue_random_op();
    drain();
  endtask

  initial begin
    in_valid = 1'b0;
    op       = VOP_ADD;
    mask     = '0;
    va       = '0;
    vb       = '0;
    vd_old   = '0;
    ovf_clr  = 1'b0;
    @(posedge nRST);
    arith_exact();
    special_values();
    round_ties_even();
    overflow_status();
    mask_merge();
    back_to_back();
    @(posedge CLK);
    #3;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 2,   // 4 ns clock
  parameter int RESET_CYCLES = 5
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(HALF_PERIOD) CLK = ~CLK;
  end

  // Release just after an edge, away from the DUT sampling point
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 nRST = 1'b1;
  end

endmodule

//--- vector_fpu_top.sv
`timescale 1ns/1ps

module vector_fpu_top import vector_pkg::*; #(
  parameter int LANES = 4
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          in_valid,
  input  vop_t                          op,
  input  logic [LANES-1:0]              mask,
  input  logic [LANES*$bits(fp16_t)-1:0] va,
  input  logic [LANES*$bits(fp16_t)-1:0] vb,
  input  logic [LANES*$bits(fp16_t)-1:0] vd_old,
  output logic                          out_valid,
  output logic [LANES*$bits(fp16_t)-1:0] vd,
  output logic [LANES-1:0]              lane_ovf,
  input  logic                          ovf_clr,
  output logic                          ovf_sticky
);

  // Flat vectors map lane 0 to the low 16 bits
  vaddsub_unit #(
    .LANES (LANES)
  ) u_vaddsub_unit (
    .CLK        (CLK),
    .nRST       (nRST),
    .in_valid   (in_valid),
    .op         (op),
    .mask       (mask),
    .va         (va),
    .vb         (vb),
    .vd_old     (vd_old),
    .out_valid  (out_valid),
    .vd         (vd),
    .lane_ovf   (lane_ovf),
    .ovf_clr    (ovf_clr),
    .ovf_sticky (ovf_sticky)
  );

endmodule

//--- vaddsub_unit.sv
`timescale 1ns/1ps

module vaddsub_unit import vector_pkg::*; #(
  parameter int LANES = 4
) (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    in_valid,
  input  vop_t                    op,
  input  logic      [LANES-1:0]   mask,
  input  fp16_t     [LANES-1:0]   va,
  input  fp16_t     [LANES-1:0]   vb,
  input  fp16_t     [LANES-1:0]   vd_old,
  output logic                    out_valid,
  output fp16_t     [LANES-1:0]   vd,
  output logic      [LANES-1:0]   lane_ovf,
  input  logic                    ovf_clr,
  output logic                    ovf_sticky
);

  // Side pipeline matching the two adder stages
  logic                valid_q1;
  logic                valid_q2;
  logic  [LANES-1:0]   mask_q1;
  logic  [LANES-1:0]   mask_q2;
  fp16_t [LANES-1:0]   vd_old_q1;
  fp16_t [LANES-1:0]   vd_old_q2;

  vaddsub_if lane_if [LANES] ();

  genvar g;
  generate
    for (g = 0; g < LANES; g++) begin : g_lane
      assign lane_if[g].enable = in_valid & mask[g];  // Masked lanes stay idle
      assign lane_if[g].port_a = va[g];
      assign lane_if[g].port_b = (op == VOP_SUB) ? {~vb[g].sign, vb[g].exp, vb[g].frac}
                                                 : vb[g];

      vaddsub u_vaddsub (
        .CLK       (CLK),
        .nRST      (nRST),
        .vaddsubif (lane_if[g].vaddsub)
      );

      // Masked-off lanes keep their old value
      always_comb begin
        if (!valid_q2) begin
          vd[g] = '0;
        end else if (mask_q2[g]) begin
          vd[g] = lane_if[g].out;
        end else begin
          vd[g] = vd_old_q2[g];
        end
      end

      assign lane_ovf[g] = valid_q2 & mask_q2[g] & lane_if[g].overflow;
    end
  endgenerate

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      valid_q1 <= 1'b0;
      valid_q2 <= 1'b0;
      mask_q1  <= '0;
      mask_q2  <= '0;
    end else begin
      valid_q1 <= in_valid;
      valid_q2 <= valid_q1;
      mask_q1  <= mask;
      mask_q2  <= mask_q1;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_valid) begin
      vd_old_q1 <= vd_old;
    end
    if (valid_q1) begin
      vd_old_q2 <= vd_old_q1;
    end
  end

  assign out_valid = valid_q2;

  // Sticky status, a new overflow beats the clear
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      ovf_sticky <= 1'b0;
    end else if (|lane_ovf) begin
      ovf_sticky <= 1'b1;
    end else if (ovf_clr) begin
      ovf_sticky <= 1'b0;
    end
  end

endmodule

//--- vaddsub.sv
`timescale 1ns/1ps

module vaddsub import vector_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  vaddsub_if.vaddsub vaddsubif
);

  localparam int EXP_W  = FP16_EXP_W;
  localparam int FRAC_W = FP16_FRAC_W;
  localparam int SIG_W  = FRAC_W + 1;   // Hidden bit plus fraction
  localparam int GRS_W  = 3;            // Guard, round, sticky
  localparam int EXT_W  = SIG_W + GRS_W;
  localparam int SUM_W  = EXT_W + 1;    // Room for carry out of the add

  // Stage 1 combinational signals
  fp16_t             a;
  fp16_t             b;
  logic              a_nan;
  logic              b_nan;
  logic              a_inf;
  logic              b_inf;
  logic              special_n;
  fp16_t             special_res_n;
  logic [SIG_W-1:0]  sig_a;
  logic [SIG_W-1:0]  sig_b;
  logic [EXP_W-1:0]  exp_a;
  logic [EXP_W-1:0]  exp_b;
  logic              swap;
  logic [SIG_W-1:0]  sig_big;
  logic [SIG_W-1:0]  sig_small;
  logic [EXP_W-1:0]  exp_big;
  logic [EXP_W-1:0]  exp_small;
  logic              sign_big;
  logic              sign_small;
  logic [EXP_W-1:0]  exp_diff;
  logic [EXP_W-1:0]  align_sh;
  logic [2*EXT_W-1:0] align_wide;
  logic [EXT_W-1:0]  small_al;
  logic              eff_add;
  logic [SUM_W-1:0]  mag_n;
  logic              sign_n;

  // Stage 1 registers
  logic              s1_v;
  logic              s1_special;
  fp16_t             s1_special_res;
  logic [SUM_W-1:0]  s1_mag;
  logic [EXP_W-1:0]  s1_exp;
  logic              s1_sign;

  // Stage 2 combinational signals
  logic [3:0]        lz;
  logic [EXP_W-1:0]  shl;
  logic [SUM_W-1:0]  norm;
  logic [EXP_W:0]    exp_n;
  logic [SIG_W-1:0]  sig_n;
  logic              guard;
  logic              rnd;
  logic              sticky;
  logic              round_up;
  logic [SIG_W:0]    sig_sum;
  logic [SIG_W-1:0]  sig_post;
  logic [EXP_W:0]    exp_post;
  fp16_t             out_n;
  logic              ovf_n;

  // Stage 2 registers
  logic              s2_v;
  fp16_t             s2_out;
  logic              s2_ovf;

  function automatic logic is_nan(input fp16_t f);
    return (f.exp == FP16_EXP_MAX) && (f.frac != '0);
  endfunction

  function automatic logic is_inf(input fp16_t f);
    return (f.exp == FP16_EXP_MAX) && (f.frac == '0);
  endfunction

  // Subnormals share the scale of exponent 1
  function automatic logic [EXP_W-1:0] eff_exp(input fp16_t f);
    return (f.exp == '0) ? EXP_W'(1) : f.exp;
  endfunction

  function automatic logic [SIG_W-1:0] full_sig(input fp16_t f);
    return {(f.exp != '0), f.frac};
  endfunction

  // Leading zeros in the aligned field, hidden bit position first
  function automatic logic [3:0] lzc(input logic [EXT_W-1:0] x);
    logic [3:0] cnt;
    logic       found;
    cnt   = 4'(EXT_W);
    found = 1'b0;
    for (int i = EXT_W - 1; i >= 0; i--) begin
      if (!found && x[i]) begin
        cnt   = 4'(EXT_W - 1 - i);
        found = 1'b1;
      end
    end
    return cnt;
  endfunction

  assign a = vaddsubif.port_a;
  assign b = vaddsubif.port_b;

  assign a_nan = is_nan(a);
  assign b_nan = is_nan(b);
  assign a_inf = is_inf(a);
  assign b_inf = is_inf(b);

  // NaN and infinity handling
  always_comb begin
    special_n     = 1'b1;
    special_res_n = FP16_QNAN;
    if (a_nan || b_nan) begin
      special_res_n = FP16_QNAN;
    end else if (a_inf && b_inf && (a.sign != b.sign)) begin
      special_res_n = FP16_QNAN;             // inf - inf
    end else if (a_inf) begin
      special_res_n = {a.sign, FP16_POS_INF[14:0]};
    end else if (b_inf) begin
      special_res_n = {b.sign, FP16_POS_INF[14:0]};
    end else begin
      special_n = 1'b0;
    end
  end

  assign sig_a = full_sig(a);
  assign sig_b = full_sig(b);
  assign exp_a = eff_exp(a);
  assign exp_b = eff_exp(b);

  // Larger magnitude goes on the big side
  assign swap = (exp_b > exp_a) || ((exp_b == exp_a) && (sig_b > sig_a));

  assign sig_big    = swap ? sig_b : sig_a;
  assign sig_small  = swap ? sig_a : sig_b;
  assign exp_big    = swap ? exp_b : exp_a;
  assign exp_small  = swap ? exp_a : exp_b;
  assign sign_big   = swap ? b.sign : a.sign;
  assign sign_small = swap ? a.sign : b.sign;

  assign exp_diff = exp_big - exp_small;
  assign align_sh = (exp_diff > EXP_W'(EXT_W)) ? EXP_W'(EXT_W) : exp_diff;

  // Shifted-out bits land in the low half and feed sticky
  assign align_wide = {sig_small, {GRS_W{1'b0}}, {EXT_W{1'b0}}} >> align_sh;
  assign small_al   = {align_wide[2*EXT_W-1:EXT_W+1],
                       align_wide[EXT_W] | (|align_wide[EXT_W-1:0])};

  assign eff_add = (sign_big == sign_small);

  always_comb begin
    if (eff_add) begin
      mag_n = {1'b0, sig_big, {GRS_W{1'b0}}} + {1'b0, small_al};
    end else begin
      mag_n = {1'b0, sig_big, {GRS_W{1'b0}}} - {1'b0, small_al};
    end
  end

  // Exact cancellation gives +0
  assign sign_n = (mag_n == '0 && !eff_add) ? 1'b0 : sign_big;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      s1_v <= 1'b0;
    end else begin
      s1_v <= vaddsubif.enable;
    end
  end

  always_ff @(posedge CLK) begin
    if (vaddsubif.enable) begin
      s1_special     <= special_n;
      s1_special_res <= special_res_n;
      s1_mag         <= mag_n;
      s1_exp         <= exp_big;
      s1_sign        <= sign_n;
    end
  end

  assign lz = lzc(s1_mag[EXT_W-1:0]);

  // Normalise, never below the subnormal scale
  always_comb begin
    shl = '0;
    if (s1_mag[SUM_W-1]) begin
      norm  = {1'b0, s1_mag[SUM_W-1:2], s1_mag[1] | s1_mag[0]};
      exp_n = {1'b0, s1_exp} + 1'b1;
    end else begin
      if (EXP_W'(lz) < s1_exp) begin
        shl = EXP_W'(lz);
      end else begin
        shl = s1_exp - 1'b1;
      end
      norm  = s1_mag << shl;
      exp_n = {1'b0, s1_exp - shl};
    end
  end

  assign sig_n  = norm[EXT_W-1:GRS_W];
  assign guard  = norm[2];
  assign rnd    = norm[1];
  assign sticky = norm[0];

  assign round_up = guard & (rnd | sticky | sig_n[0]);  // Ties to even
  assign sig_sum  = {1'b0, sig_n} + round_up;

  // Carry out of rounding bumps the exponent
  assign sig_post = sig_sum[SIG_W] ? {1'b1, {FRAC_W{1'b0}}} : sig_sum[SIG_W-1:0];
  assign exp_post = exp_n + sig_sum[SIG_W];

  always_comb begin
    ovf_n = 1'b0;
    if (s1_special) begin
      out_n = s1_special_res;
    end else if (exp_post >= {1'b0, FP16_EXP_MAX}) begin
      out_n = {s1_sign, FP16_POS_INF[14:0]};
      ovf_n = 1'b1;
    end else if (!sig_post[FRAC_W]) begin
      out_n = {s1_sign, {EXP_W{1'b0}}, sig_post[FRAC_W-1:0]};  // Subnormal or zero
    end else begin
      out_n = {s1_sign, exp_post[EXP_W-1:0], sig_post[FRAC_W-1:0]};
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      s2_v <= 1'b0;
    end else begin
      s2_v <= s1_v;
    end
  end

  always_ff @(posedge CLK) begin
    if (s1_v) begin
      s2_out <= out_n;
      s2_ovf <= ovf_n;
    end
  end

  assign vaddsubif.out      = s2_v ? s2_out : '0;
  assign vaddsubif.overflow = s2_v & s2_ovf;

endmodule

//--- vaddsub_if.sv
`timescale 1ns/1ps

interface vaddsub_if import vector_pkg::*; ();

  fp16_t port_a;    // Operand A
  fp16_t port_b;    // Operand B, sign already adjusted for subtract
  logic  enable;    // Start strobe, one op per cycle
  fp16_t out;       // Result, zero when not valid
  logic  overflow;  // Result saturated to infinity

  // Lane adder side
  modport vaddsub (
    input  port_a,
    input  port_b,
    input  enable,
    output out,
    output overflow
  );

  // Vector unit side
  modport unit (
    output port_a,
    output port_b,
    output enable,
    input  out,
    input  overflow
  );

endinterface

//--- vector_pkg.sv
package vector_pkg;

  // fp16 field widths
  localparam int FP16_EXP_W  = 5;
  localparam int FP16_FRAC_W = 10;

  // IEEE half precision element
  typedef struct packed {
    logic                   sign;
    logic [FP16_EXP_W-1:0]  exp;
    logic [FP16_FRAC_W-1:0] frac;
  } fp16_t;

  // Vector opcodes handled by the add/sub unit
  typedef enum logic {
    VOP_ADD = 1'b0,
    VOP_SUB = 1'b1
  } vop_t;

  // Exponent value reserved for inf and NaN
  localparam logic [FP16_EXP_W-1:0] FP16_EXP_MAX = 5'd31;

  // Canonical quiet NaN, positive sign
  localparam fp16_t FP16_QNAN = 16'h7E00;

  // Positive infinity, set the sign bit for -inf
  localparam fp16_t FP16_POS_INF = 16'h7C00;

endpackage
